//--- Makefile
VERILATOR ?= verilator
TOP ?= ExecCoreTb
BUILD_DIR ?= build
VFLAGS ?= --binary

SOURCES := $(shell grep -v '^+' all.f)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): all.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f all.f

run: $(BIN)
	@out="$$(./$(BIN))"; status=$$?; echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS" && [ $$status -eq 0 ]

clean:
	rm -rf $(BUILD_DIR)

//--- all.f
hw/CoreTypes.sv
hw/OpTypes.sv
hw/DecodeStage.sv
hw/RegReadStage.sv
hw/MulDivUnit.sv
hw/ExecuteStage.sv
hw/ExecCore.sv
testbench/ExecCoreTb.sv

//--- hw/CoreTypes.sv
/*
 * Word and register-address types and the size constants of the core.
 * Imported by every RTL module.
 */
`default_nettype none

package CoreTypes;

    localparam int XLen = 32;
    localparam int XLenLog2 = 5;
    localparam int InsnSize = 4;
    localparam int RegCount = 32;

    typedef logic [XLen-1:0] word;
    typedef logic [4:0] regAddr;

endpackage

`default_nettype wire

//--- hw/DecodeStage.sv
/*
 * First pipeline stage. Splits an RV32IM instruction word into control
 * fields, register addresses and the immediate, and registers them.
 * The register holds its contents while stall is high.
 */
`default_nettype none

module DecodeStage import CoreTypes::*, OpTypes::*; (
    input logic clk,
    input logic rstN,
    input logic stall,
    input logic insnValid,
    input word insn,
    input word pc,
    output logic decValid,
    output word decPc,
    output regAddr rs1,
    output regAddr rs2,
    output regAddr rd,
    output word decImm,
    output AluCommand aluCommand,
    output BranchType branchType,
    output AluSrc1 aluSrc1,
    output AluSrc2 aluSrc2,
    output MulDivOp mulDivOp,
    output ResultSrc resultSrc,
    output logic regWrite,
    output logic decIllegal
);
    Opcode opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word immI, immU, immB, immJ, imm;
    AluCommand alu;
    BranchType branch;
    AluSrc1 src1Sel;
    AluSrc2 src2Sel;
    MulDivOp mdOp;
    ResultSrc resSel;
    logic write, bad;

    function automatic AluCommand aluFromFunct3(logic [2:0] f3);
        case (f3)
            3'b000: return AluCommand_Add;
            3'b001: return AluCommand_Sll;
            3'b010: return AluCommand_Slt;
            3'b011: return AluCommand_Sltu;
            3'b100: return AluCommand_Xor;
            3'b101: return AluCommand_Srl;
            3'b110: return AluCommand_Or;
            default: return AluCommand_And;
        endcase
    endfunction

    assign opcode = Opcode'(insn[6:0]);
    assign funct3 = insn[14:12];
    assign funct7 = insn[31:25];

    assign immI = {{20{insn[31]}}, insn[31:20]};
    assign immU = {insn[31:12], 12'b0};
    assign immB = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    assign immJ = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

    always_comb begin
        alu = aluFromFunct3(funct3);
        branch = BranchType_Never;
        src1Sel = AluSrc1_Reg;
        src2Sel = AluSrc2_Imm;
        mdOp = MulDivOp_Mul;
        resSel = ResultSrc_Alu;
        imm = immI;
        write = 1'b1;
        bad = 1'b0;
        case (opcode)
            Opcode_Lui: begin
                src1Sel = AluSrc1_Zero;
                alu = AluCommand_Add;
                imm = immU;
            end
            Opcode_Auipc: begin
                src1Sel = AluSrc1_Pc;
                alu = AluCommand_Add;
                imm = immU;
            end
            Opcode_Jal: begin
                src1Sel = AluSrc1_Pc;
                alu = AluCommand_Add;
                imm = immJ;
                branch = BranchType_Always;
                resSel = ResultSrc_NextPc;
            end
            Opcode_Jalr: begin
                alu = AluCommand_Add;
                branch = BranchType_Always;
                resSel = ResultSrc_NextPc;
                bad = funct3 != 3'b000;
            end
            Opcode_Branch: begin
                src1Sel = AluSrc1_Pc;
                alu = AluCommand_Add;
                imm = immB;
                write = 1'b0;
                case (funct3)
                    3'b000: branch = BranchType_Equal;
                    3'b001: branch = BranchType_NotEqual;
                    3'b100: branch = BranchType_LessThan;
                    3'b101: branch = BranchType_GreaterEqual;
                    3'b110: branch = BranchType_UnsignedLessThan;
                    3'b111: branch = BranchType_UnsignedGreaterEqual;
                    default: bad = 1'b1;
                endcase
            end
            Opcode_OpImm: begin
                // shift immediates carry funct7 in the upper bits
                if (funct3 == 3'b001) begin
                    bad = funct7 != 7'b0000000;
                end else if (funct3 == 3'b101 && funct7 == 7'b0100000) begin
                    alu = AluCommand_Sra;
                end else if (funct3 == 3'b101) begin
                    bad = funct7 != 7'b0000000;
                end
            end
            Opcode_Op: begin
                src2Sel = AluSrc2_Reg;
                case (funct7)
                    7'b0000000: ;
                    7'b0100000: begin
                        if (funct3 == 3'b000) begin
                            alu = AluCommand_Sub;
                        end else if (funct3 == 3'b101) begin
                            alu = AluCommand_Sra;
                        end else begin
                            bad = 1'b1;
                        end
                    end
                    7'b0000001: begin
                        resSel = ResultSrc_MulDiv;
                        case (funct3)
                            3'b000: mdOp = MulDivOp_Mul;
                            3'b011: mdOp = MulDivOp_Mulhu;
                            3'b100: mdOp = MulDivOp_Div;
                            3'b101: mdOp = MulDivOp_Divu;
                            3'b110: mdOp = MulDivOp_Rem;
                            3'b111: mdOp = MulDivOp_Remu;
                            // mulh and mulhsu are not supported
                            default: bad = 1'b1;
                        endcase
                    end
                    default: bad = 1'b1;
                endcase
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            write = 1'b0;
            branch = BranchType_Never;
            resSel = ResultSrc_Alu;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            decValid <= 1'b0;
        end else if (!stall) begin
            decValid <= insnValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            decPc <= pc;
            rs1 <= insn[19:15];
            rs2 <= insn[24:20];
            rd <= insn[11:7];
            decImm <= imm;
            aluCommand <= alu;
            branchType <= branch;
            aluSrc1 <= src1Sel;
            aluSrc2 <= src2Sel;
            mulDivOp <= mdOp;
            resultSrc <= resSel;
            regWrite <= write;
            decIllegal <= bad;
        end
    end

endmodule

`default_nettype wire

//--- hw/ExecCore.sv
/*
 * Top level of the integer execution path. Chains decode, register read
 * and execute; the outside follows stall and redirect.
 */
`default_nettype none

module ExecCore import CoreTypes::*, OpTypes::*; (
    input logic clk,
    input logic rstN,
    input logic insnValid,
    input word insn,
    input word pc,
    output logic stall,
    output logic wbValid,
    output logic wbWrite,
    output regAddr wbRegAddr,
    output word wbValue,
    output logic redirect,
    output word redirectTarget,
    output logic illegal
);
    // stage fields, connected by name
    logic decValid, regWrite, decIllegal;
    logic rrValid, rrRegWrite, rrIllegal;
    word decPc, decImm, rrPc, rrImm, rrSrc1, rrSrc2;
    regAddr rs1, rs2, rd, rrRs1, rrRs2, rrRd;
    AluCommand aluCommand, rrAluCommand;
    BranchType branchType, rrBranchType;
    AluSrc1 aluSrc1, rrAluSrc1;
    AluSrc2 aluSrc2, rrAluSrc2;
    MulDivOp mulDivOp, rrMulDivOp;
    ResultSrc resultSrc, rrResultSrc;

    DecodeStage decode (.*);

    RegReadStage regRead (.*);

    ExecuteStage execute (.*);

endmodule

`default_nettype wire

//--- hw/ExecuteStage.sv
/*
 * Third pipeline stage. Bypasses operands from its own output register,
 * runs the ALU, branch compare and multiply/divide unit, and registers
 * the writeback and redirect. Stalls earlier stages during multiply/divide.
 */
`default_nettype none

module ExecuteStage import CoreTypes::*, OpTypes::*; (
    input logic clk,
    input logic rstN,
    input logic rrValid,
    input word rrPc,
    input regAddr rrRs1,
    input regAddr rrRs2,
    input regAddr rrRd,
    input word rrImm,
    input AluCommand rrAluCommand,
    input BranchType rrBranchType,
    input AluSrc1 rrAluSrc1,
    input AluSrc2 rrAluSrc2,
    input MulDivOp rrMulDivOp,
    input ResultSrc rrResultSrc,
    input logic rrRegWrite,
    input logic rrIllegal,
    input word rrSrc1,
    input word rrSrc2,
    output logic stall,
    output logic wbValid,
    output logic wbWrite,
    output regAddr wbRegAddr,
    output word wbValue,
    output logic redirect,
    output word redirectTarget,
    output logic illegal
);
    word src1, src2, aluIn1, aluIn2, aluResult, dstValue, mdResult;
    logic taken, mdActive, mdStart, mdDone, mdBusy;

    MulDivUnit mulDiv (
        .clk,
        .rstN,
        .start(mdStart),
        .op(rrMulDivOp),
        .src1,
        .src2,
        .done(mdDone),
        .result(mdResult)
    );

    always_comb begin
        src1 = (wbWrite && wbRegAddr == rrRs1) ? wbValue : rrSrc1;
        src2 = (wbWrite && wbRegAddr == rrRs2) ? wbValue : rrSrc2;

        case (rrAluSrc1)
            AluSrc1_Pc: aluIn1 = rrPc;
            AluSrc1_Reg: aluIn1 = src1;
            default: aluIn1 = '0;
        endcase
        aluIn2 = (rrAluSrc2 == AluSrc2_Reg) ? src2 : rrImm;

        case (rrAluCommand)
            AluCommand_Sub: aluResult = aluIn1 - aluIn2;
            AluCommand_Sll: aluResult = aluIn1 << aluIn2[XLenLog2-1:0];
            AluCommand_Slt: aluResult = word'($signed(aluIn1) < $signed(aluIn2));
            AluCommand_Sltu: aluResult = word'(aluIn1 < aluIn2);
            AluCommand_Xor: aluResult = aluIn1 ^ aluIn2;
            AluCommand_Srl: aluResult = aluIn1 >> aluIn2[XLenLog2-1:0];
            AluCommand_Sra: aluResult = word'($signed(aluIn1) >>> aluIn2[XLenLog2-1:0]);
            AluCommand_Or: aluResult = aluIn1 | aluIn2;
            AluCommand_And: aluResult = aluIn1 & aluIn2;
            default: aluResult = aluIn1 + aluIn2;
        endcase

        // compare always uses the register operands
        case (rrBranchType)
            BranchType_Equal: taken = src1 == src2;
            BranchType_NotEqual: taken = src1 != src2;
            BranchType_LessThan: taken = $signed(src1) < $signed(src2);
            BranchType_GreaterEqual: taken = $signed(src1) >= $signed(src2);
            BranchType_UnsignedLessThan: taken = src1 < src2;
            BranchType_UnsignedGreaterEqual: taken = src1 >= src2;
            BranchType_Always: taken = 1'b1;
            default: taken = 1'b0;
        endcase

        case (rrResultSrc)
            ResultSrc_MulDiv: dstValue = mdResult;
            ResultSrc_NextPc: dstValue = rrPc + InsnSize;
            default: dstValue = aluResult;
        endcase
    end

    assign mdActive = rrValid && !rrIllegal && rrResultSrc == ResultSrc_MulDiv;
    assign mdStart = mdActive && !mdBusy;
    assign stall = mdActive && !mdDone;

    always_ff @(posedge clk) begin
        if (!rstN || mdDone) begin
            mdBusy <= 1'b0;
        end else if (mdStart) begin
            mdBusy <= 1'b1;
        end
    end

    // bubble while stalled
    always_ff @(posedge clk) begin
        if (!rstN || stall) begin
            wbValid <= 1'b0;
            wbWrite <= 1'b0;
            redirect <= 1'b0;
            illegal <= 1'b0;
        end else begin
            wbValid <= rrValid;
            wbWrite <= rrValid && rrRegWrite && !rrIllegal && rrRd != 5'd0;
            redirect <= rrValid && taken;
            illegal <= rrValid && rrIllegal;
        end
    end

    // targets from pc are already even, so clearing bit 0 only matters for jalr
    always_ff @(posedge clk) begin
        wbRegAddr <= rrRd;
        wbValue <= dstValue;
        redirectTarget <= {aluResult[XLen-1:1], 1'b0};
    end

endmodule

`default_nettype wire

//--- hw/MulDivUnit.sv
/*
 * Iterative multiply/divide unit, one bit per cycle.
 * A start pulse latches the operands; done pulses 33 cycles later with
 * the result. Signed division runs on magnitudes and fixes signs at the end.
 */
`default_nettype none

module MulDivUnit import CoreTypes::*, OpTypes::*; (
    input logic clk,
    input logic rstN,
    input logic start,
    input MulDivOp op,
    input word src1,
    input word src2,
    output logic done,
    output word result
);
    typedef enum logic [1:0] {Idle, Run, Finish} UnitState;

    UnitState state;
    logic [XLenLog2-1:0] count;
    MulDivOp opReg;
    // acc is the product high half or the partial remainder
    word acc, low, operand;
    logic negQuot, negRem, isSigned, isDiv;
    word absSrc1, absSrc2;
    logic [XLen:0] addSum, remShift, remDiff;

    assign isSigned = op == MulDivOp_Div || op == MulDivOp_Rem;
    assign absSrc1 = (isSigned && src1[XLen-1]) ? -src1 : src1;
    assign absSrc2 = (isSigned && src2[XLen-1]) ? -src2 : src2;
    assign isDiv = opReg != MulDivOp_Mul && opReg != MulDivOp_Mulhu;

    assign addSum = {1'b0, acc} + {1'b0, low[0] ? operand : {XLen{1'b0}}};
    assign remShift = {acc, low[XLen-1]};
    assign remDiff = remShift - {1'b0, operand};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= Idle;
        end else begin
            case (state)
                Idle: if (start) state <= Run;
                Run: if (count == XLenLog2'(XLen - 1)) state <= Finish;
                default: state <= Idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == Idle && start) begin
            opReg <= op;
            count <= '0;
            acc <= '0;
            low <= absSrc1;
            operand <= absSrc2;
            // a zero divisor keeps the all-ones quotient unsigned
            negQuot <= isSigned && (src1[XLen-1] ^ src2[XLen-1]) && src2 != '0;
            negRem <= isSigned && src1[XLen-1];
        end else if (state == Run) begin
            count <= count + 1'b1;
            if (!isDiv) begin
                {acc, low} <= {addSum, low[XLen-1:1]};
            end else if (!remDiff[XLen]) begin
                acc <= remDiff[XLen-1:0];
                low <= {low[XLen-2:0], 1'b1};
            end else begin
                acc <= remShift[XLen-1:0];
                low <= {low[XLen-2:0], 1'b0};
            end
        end
    end

    assign done = state == Finish;

    always_comb begin
        case (opReg)
            MulDivOp_Mul: result = low;
            MulDivOp_Mulhu: result = acc;
            MulDivOp_Div, MulDivOp_Divu: result = negQuot ? -low : low;
            default: result = negRem ? -acc : acc;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/OpTypes.sv
/*
 * Operation encodings shared by the decoder and the execute stage.
 * Also holds the major opcodes of the supported RV32IM instructions.
 */
`default_nettype none

package OpTypes;

    typedef enum logic [6:0] {
        Opcode_Lui = 7'b0110111,
        Opcode_Auipc = 7'b0010111,
        Opcode_Jal = 7'b1101111,
        Opcode_Jalr = 7'b1100111,
        Opcode_Branch = 7'b1100011,
        Opcode_OpImm = 7'b0010011,
        Opcode_Op = 7'b0110011
    } Opcode;

    typedef enum logic [3:0] {
        AluCommand_Add,
        AluCommand_Sub,
        AluCommand_Sll,
        AluCommand_Slt,
        AluCommand_Sltu,
        AluCommand_Xor,
        AluCommand_Srl,
        AluCommand_Sra,
        AluCommand_Or,
        AluCommand_And
    } AluCommand;

    typedef enum logic [2:0] {
        BranchType_Never,
        BranchType_Equal,
        BranchType_NotEqual,
        BranchType_LessThan,
        BranchType_GreaterEqual,
        BranchType_UnsignedLessThan,
        BranchType_UnsignedGreaterEqual,
        BranchType_Always
    } BranchType;

    typedef enum logic [1:0] {AluSrc1_Zero, AluSrc1_Pc, AluSrc1_Reg} AluSrc1;

    typedef enum logic {AluSrc2_Imm, AluSrc2_Reg} AluSrc2;

    typedef enum logic [2:0] {
        MulDivOp_Mul,
        MulDivOp_Mulhu,
        MulDivOp_Div,
        MulDivOp_Divu,
        MulDivOp_Rem,
        MulDivOp_Remu
    } MulDivOp;

    typedef enum logic [1:0] {ResultSrc_Alu, ResultSrc_MulDiv, ResultSrc_NextPc} ResultSrc;

endpackage

`default_nettype wire

//--- hw/RegReadStage.sv
/*
 * Second pipeline stage. Holds the integer register file, written from
 * the execute stage, and registers both operands with the decoded fields.
 * A write in the current cycle is visible to the read in that cycle.
 */
`default_nettype none

module RegReadStage import CoreTypes::*, OpTypes::*; (
    input logic clk,
    input logic rstN,
    input logic stall,
    input logic decValid,
    input word decPc,
    input regAddr rs1,
    input regAddr rs2,
    input regAddr rd,
    input word decImm,
    input AluCommand aluCommand,
    input BranchType branchType,
    input AluSrc1 aluSrc1,
    input AluSrc2 aluSrc2,
    input MulDivOp mulDivOp,
    input ResultSrc resultSrc,
    input logic regWrite,
    input logic decIllegal,
    input logic wbWrite,
    input regAddr wbRegAddr,
    input word wbValue,
    output logic rrValid,
    output word rrPc,
    output regAddr rrRs1,
    output regAddr rrRs2,
    output regAddr rrRd,
    output word rrImm,
    output AluCommand rrAluCommand,
    output BranchType rrBranchType,
    output AluSrc1 rrAluSrc1,
    output AluSrc2 rrAluSrc2,
    output MulDivOp rrMulDivOp,
    output ResultSrc rrResultSrc,
    output logic rrRegWrite,
    output logic rrIllegal,
    output word rrSrc1,
    output word rrSrc2
);
    // x0 has no storage
    word regs [1:RegCount-1];
    word readA, readB;

    always_ff @(posedge clk) begin
        if (wbWrite) begin
            regs[wbRegAddr] <= wbValue;
        end
    end

    always_comb begin
        if (rs1 == 5'd0) begin
            readA = '0;
        end else if (wbWrite && wbRegAddr == rs1) begin
            readA = wbValue;
        end else begin
            readA = regs[rs1];
        end
        if (rs2 == 5'd0) begin
            readB = '0;
        end else if (wbWrite && wbRegAddr == rs2) begin
            readB = wbValue;
        end else begin
            readB = regs[rs2];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rrValid <= 1'b0;
        end else if (!stall) begin
            rrValid <= decValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            rrPc <= decPc;
            rrRs1 <= rs1;
            rrRs2 <= rs2;
            rrRd <= rd;
            rrImm <= decImm;
            rrAluCommand <= aluCommand;
            rrBranchType <= branchType;
            rrAluSrc1 <= aluSrc1;
            rrAluSrc2 <= aluSrc2;
            rrMulDivOp <= mulDivOp;
            rrResultSrc <= resultSrc;
            rrRegWrite <= regWrite;
            rrIllegal <= decIllegal;
            rrSrc1 <= readA;
            rrSrc2 <= readB;
        end
    end

endmodule

`default_nettype wire

//--- testbench/ExecCoreTb.sv
/*
 * Testbench for the execution path. Reads instructions and expected
 * results from testbench/execInput.txt, drives them into the DUT while
 * following stall, and checks each retired instruction in order.
 */
`default_nettype none

module ExecCoreTb import CoreTypes::*; ();

    localparam int MaxLines = 64;

    logic clk;
    logic rstN;
    logic insnValid;
    word insn;
    word pc;
    logic stall;
    logic wbValid;
    logic wbWrite;
    regAddr wbRegAddr;
    word wbValue;
    logic redirect;
    word redirectTarget;
    logic illegal;

    word lineInsn [MaxLines];
    word linePc [MaxLines];
    logic lineWrite [MaxLines];
    regAddr lineAddr [MaxLines];
    word lineValue [MaxLines];
    logic lineRedirect [MaxLines];
    word lineTarget [MaxLines];
    logic lineIllegal [MaxLines];

    int lineCount = 0;
    int checkIdx = 0;
    int cycleCount = 0;
    int cycleLimit = 0;
    logic stallBefore = 1'b0;
    // stall seen since the last retired instruction
    logic stallSeen = 1'b0;

    ExecCore UUT (
        .clk,
        .rstN,
        .insnValid,
        .insn,
        .pc,
        .stall,
        .wbValid,
        .wbWrite,
        .wbRegAddr,
        .wbValue,
        .redirect,
        .redirectTarget,
        .illegal
    );

    // supported M-extension ops hold the pipe while they run
    function automatic logic isMulDiv(input word insnWord);
        return insnWord[6:0] == 7'b0110011 && insnWord[31:25] == 7'b0000001
            && insnWord[14:12] != 3'b001 && insnWord[14:12] != 3'b010;
    endfunction

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "stopped on first failure");
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error %s: expected %b, actual %b", name, expected, actual);
            failRun("flag mismatch");
        end
    endtask

    task automatic checkWb(input string name, input regAddr expAddr, input word expValue);
        if (wbRegAddr !== expAddr) begin
            $display("Error %s addr: expected %0d, actual %0d", name, expAddr, wbRegAddr);
            failRun("writeback address mismatch");
        end
        if (wbValue !== expValue) begin
            $display("Error %s value: expected %h, actual %h", name, expValue, wbValue);
            failRun("writeback value mismatch");
        end
    endtask

    task automatic checkRedirect(input string name, input logic expFlag, input word expTarget);
        if (redirect !== expFlag) begin
            $display("Error %s redirect: expected %b, actual %b", name, expFlag, redirect);
            failRun("redirect flag mismatch");
        end
        if (expFlag && redirectTarget !== expTarget) begin
            $display("Error %s target: expected %h, actual %h", name, expTarget,
                redirectTarget);
            failRun("redirect target mismatch");
        end
    endtask

    task automatic readInput();
        int fd;
        int code;
        word fInsn, fPc, fValue, fTarget;
        logic [3:0] fWrite, fRedirect, fIllegal;
        logic [7:0] fAddr;
        fd = $fopen("testbench/execInput.txt", "r");
        if (fd == 0) begin
            failRun("could not open testbench/execInput.txt");
        end
        while (!$feof(fd) && lineCount < MaxLines) begin
            code = $fscanf(fd, " %h %h %h %h %h %h %h %h", fInsn, fPc, fWrite, fAddr,
                fValue, fRedirect, fTarget, fIllegal);
            if (code == 8) begin
                lineInsn[lineCount] = fInsn;
                linePc[lineCount] = fPc;
                lineWrite[lineCount] = fWrite[0];
                lineAddr[lineCount] = fAddr[4:0];
                lineValue[lineCount] = fValue;
                lineRedirect[lineCount] = fRedirect[0];
                lineTarget[lineCount] = fTarget;
                lineIllegal[lineCount] = fIllegal[0];
                lineCount++;
            end else if (!$feof(fd)) begin
                failRun("input file holds a malformed line");
            end
        end
        $fclose(fd);
        if (lineCount == 0) begin
            failRun("input file holds no test lines");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // stall is stable between edges
    always @(negedge clk) begin
        stallBefore = stall;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            failRun("timed out before all results came back");
        end
    end

    always @(negedge clk) begin
        string name;
        if (rstN === 1'b1 && wbValid === 1'b1) begin
            if (checkIdx >= lineCount) begin
                failRun("more instructions retired than were sent");
            end
            name = $sformatf("line %0d pc %h", checkIdx, linePc[checkIdx]);
            checkFlag({name, " illegal"}, lineIllegal[checkIdx], illegal);
            checkFlag({name, " wbWrite"}, lineWrite[checkIdx], wbWrite);
            checkFlag({name, " stall"}, isMulDiv(lineInsn[checkIdx]), stallSeen);
            // the next instruction may already stall in this cycle
            stallSeen = (stall === 1'b1);
            if (lineWrite[checkIdx]) begin
                checkWb(name, lineAddr[checkIdx], lineValue[checkIdx]);
            end
            checkRedirect(name, lineRedirect[checkIdx], lineTarget[checkIdx]);
            checkIdx++;
            if (checkIdx == lineCount) begin
                $display("RESULT: PASS");
                $finish;
            end
        end else if (stall === 1'b1) begin
            stallSeen = 1'b1;
        end
    end

    initial begin
        int idx;
        rstN = 1'b0;
        insnValid = 1'b0;
        insn = '0;
        pc = '0;
        readInput();
        // slowest case is a multiply/divide on every line
        cycleLimit = lineCount * 40 + 100;
        repeat (8) @(posedge clk);
        #1;
        rstN = 1'b1;
        idx = 0;
        insnValid = 1'b1;
        insn = lineInsn[0];
        pc = linePc[0];
        while (idx < lineCount) begin
            @(posedge clk);
            if (!stallBefore) begin
                idx++;
            end
            #1;
            if (idx < lineCount) begin
                insn = lineInsn[idx];
                pc = linePc[idx];
            end else begin
                insnValid = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/execInput.txt
00500093 00000100 1 01 00000005 0 00000000 0
ff800113 00000104 1 02 fffffff8 0 00000000 0
002081b3 00000108 1 03 fffffffd 0 00000000 0
40118233 0000010c 1 04 fffffff8 0 00000000 0
40215293 00000110 1 05 fffffffe 0 00000000 0
0020b333 00000114 1 06 00000001 0 00000000 0
001123b3 00000118 1 07 00000001 0 00000000 0
12345437 0000011c 1 08 12345000 0 00000000 0
00001497 00000120 1 09 00001120 0 00000000 0
fff44513 00000124 1 0a edcbafff 0 00000000 0
001155b3 00000128 1 0b 07ffffff 0 00000000 0
00708013 0000012c 0 00 00000000 0 00000000 0
00100633 00000130 1 0c 00000005 0 00000000 0
0000000b 00000134 0 00 00000000 0 00000000 1
00c08463 00000138 0 00 00000000 1 00000140 0
00c09463 00000140 0 00 00000000 0 00000000 0
fe114ee3 00000144 0 00 00000000 1 00000140 0
00115463 00000140 0 00 00000000 0 00000000 0
0020e863 00000144 0 00 00000000 1 00000154 0
0020f463 00000154 0 00 00000000 0 00000000 0
020006ef 00000158 1 0d 0000015c 1 00000178 0
01168767 00000178 1 0e 0000017c 1 0000016c 0
025107b3 0000016c 1 0f 00000010 0 00000000 0
02213833 00000170 1 10 fffffff0 0 00000000 0
0257c8b3 00000174 1 11 fffffff8 0 00000000 0
0208d933 00000178 1 12 ffffffff 0 00000000 0
0208e9b3 0000017c 1 13 fffffff8 0 00000000 0
80000a37 00000180 1 14 80000000 0 00000000 0
fff00a93 00000184 1 15 ffffffff 0 00000000 0
035a4b33 00000188 1 16 80000000 0 00000000 0
035a6bb3 0000018c 1 17 00000000 0 00000000 0
021a7c33 00000190 1 18 00000003 0 00000000 0
016c0cb3 00000194 1 19 80000003 0 00000000 0
418c8d33 00000198 1 1a 80000000 0 00000000 0
